/* design/eth_pkg.sv */
package eth_pkg;

	// one gmii lane, byte wide
	typedef struct packed {
		logic		en;		// frame in progress
		logic		er;		// phy reports a symbol error
		logic [7:0]	data;
	} gmii_bus_t;

	// receive stream up to the stack
	typedef struct packed {
		logic		start;		// one cycle ahead of first body byte
		logic		data_valid;
		logic [7:0]	data;
		logic		commit;		// frame passed all checks
		logic		drop;		// frame failed, discard what was passed up
	} eth_rx_bus_t;

	// transmit stream from the stack
	typedef struct packed {
		logic		start;		// bytes follow on the next cycles
		logic		data_valid;	// first low cycle ends the frame
		logic [7:0]	data;
	} eth_tx_bus_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_BODY,
		RX_DISCARD		// malformed start, wait for en to drop
	} rx_state_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_BODY,
		TX_PAD,
		TX_FCS,
		TX_GAP
	} tx_state_t;

	// counter selector, values double as counter index
	typedef enum logic [1:0] {
		RX_GOOD		= 2'd0,
		RX_CRC_ERR	= 2'd1,
		RX_RUNT		= 2'd2,
		TX_FRAMES	= 2'd3
	} perf_sel_t;

	localparam logic [7:0]	PREAMBLE_BYTE	= 8'h55;
	localparam logic [7:0]	SFD_BYTE	= 8'hd5;
	localparam int		MIN_BODY_BYTES	= 60;		// excludes fcs
	localparam int		FCS_BYTES	= 4;
	localparam int		IFG_CYCLES	= 12;

	// crc register after a clean frame plus its fcs, msb-first form
	localparam logic [31:0]	CRC_RESIDUE	= 32'hc704dd7b;

endpackage

/* design/eth_crc32.sv */
`timescale 1ns/1ps

module eth_crc32 (
	input  logic		clk_125mhz,
	input  logic		rst,
	input  logic		init,		// preset to all ones
	input  logic		update,		// fold in data this cycle
	input  logic [7:0]	data,
	output logic [31:0]	crc		// raw register, not inverted
);

	localparam logic [31:0] POLY = 32'hedb88320;	// 802.3 polynomial, lsb-first form

	// one byte, lsb first as it goes on the wire
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ POLY;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge clk_125mhz) begin
		if (rst || init)
			crc <= '1;
		else if (update)
			crc <= crc_byte(crc, data);
	end

endmodule

/* design/gmii_rx_framer.sv */
`timescale 1ns/1ps

module gmii_rx_framer import eth_pkg::*; (
	input  logic		clk_125mhz,
	input  logic		rst,
	input  gmii_bus_t	gmii_rx,
	output eth_rx_bus_t	rx_bus,
	output logic		rx_good,
	output logic		rx_crc_err,
	output logic		rx_runt
);

	localparam logic [6:0] FRAME_MIN = 7'(MIN_BODY_BYTES + FCS_BYTES);	// body plus fcs

	rx_state_t		state;
	logic [3:0][7:0]	hold;		// holding pipe, hold[3] is oldest
	logic [2:0]		fill;		// bytes in the pipe, stops at 4
	logic [6:0]		byte_cnt;	// bytes after sfd, stops at FRAME_MIN
	logic			er_seen;	// er rose somewhere in the body
	logic			commit_q;
	logic			crc_err_q;
	logic			runt_q;
	logic			body_byte;
	logic			sfd_hit;
	logic [31:0]		crc;
	logic [31:0]		crc_msb;
	logic			crc_ok;
	logic			long_ok;

	assign body_byte = (state == RX_BODY) && gmii_rx.en;
	assign sfd_hit   = (state == RX_PREAMBLE) && gmii_rx.en && (gmii_rx.data == SFD_BYTE);
	assign crc_msb   = {<<{crc}};		// residue constant is msb-first
	assign crc_ok    = (crc_msb == CRC_RESIDUE);
	assign long_ok   = (byte_cnt == FRAME_MIN);

	// every byte after sfd goes through, fcs included
	eth_crc32 u_crc (
		.clk_125mhz	(clk_125mhz),
		.rst		(rst),
		.init		(sfd_hit),
		.update		(body_byte),
		.data		(gmii_rx.data),
		.crc		(crc)
	);

	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			state     <= RX_IDLE;
			fill      <= '0;
			byte_cnt  <= '0;
			er_seen   <= 1'b0;
			commit_q  <= 1'b0;
			crc_err_q <= 1'b0;
			runt_q    <= 1'b0;
		end else begin
			commit_q  <= 1'b0;		// verdicts are single pulses
			crc_err_q <= 1'b0;
			runt_q    <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (gmii_rx.en)
						state <= (gmii_rx.data == PREAMBLE_BYTE) ? RX_PREAMBLE : RX_DISCARD;
				end
				RX_PREAMBLE: begin
					if (!gmii_rx.en) begin
						state <= RX_IDLE;	// ended inside preamble, nothing to report
					end else if (sfd_hit) begin
						state    <= RX_BODY;
						fill     <= '0;
						byte_cnt <= '0;
						er_seen  <= 1'b0;
					end else if (gmii_rx.data != PREAMBLE_BYTE) begin
						state <= RX_DISCARD;
					end
				end
				RX_BODY: begin
					if (gmii_rx.en) begin
						if (fill != 3'd4)
							fill <= fill + 3'd1;
						if (!long_ok)
							byte_cnt <= byte_cnt + 7'd1;
						if (gmii_rx.er)
							er_seen <= 1'b1;
					end else begin
						state     <= RX_IDLE;
						commit_q  <= crc_ok && !er_seen && long_ok;
						crc_err_q <= !crc_ok || er_seen;	// er counts as a crc failure
						runt_q    <= crc_ok && !er_seen && !long_ok;
					end
				end
				RX_DISCARD: begin
					if (!gmii_rx.en)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_125mhz) begin
		if (body_byte)
			hold <= {hold[2:0], gmii_rx.data};
	end

	// a held byte leaves only when a fifth byte arrives behind it, so fcs stays back
	always_comb begin
		rx_bus.start      = body_byte && (fill == 3'd3);
		rx_bus.data_valid = body_byte && (fill == 3'd4);
		rx_bus.data       = hold[3];
		rx_bus.commit     = commit_q;
		rx_bus.drop       = crc_err_q || runt_q;
	end

	assign rx_good    = commit_q;
	assign rx_crc_err = crc_err_q;
	assign rx_runt    = runt_q;

	assert property (@(posedge clk_125mhz) disable iff (rst)
		!(rx_bus.commit && rx_bus.drop))
		else $error("rx framer: commit and drop together");

endmodule

/* design/gmii_tx_framer.sv */
`timescale 1ns/1ps

module gmii_tx_framer import eth_pkg::*; (
	input  logic		clk_125mhz,
	input  logic		rst,
	input  eth_tx_bus_t	tx_bus,
	output logic		tx_ready,
	output gmii_bus_t	gmii_tx,
	output logic		tx_done
);

	localparam logic [6:0] PRE_LAST = 7'd6;			// last cnt of preamble, sfd goes out here
	localparam logic [6:0] PAD_LEN  = 7'(MIN_BODY_BYTES);
	localparam logic [6:0] FCS_LAST = 7'(FCS_BYTES - 1);
	localparam logic [6:0] GAP_LAST = 7'(IFG_CYCLES);

	tx_state_t		state;
	logic [6:0]		cnt;		// preamble index, body length, fcs index or gap count
	logic			accepting;	// input frame still delivering bytes
	logic [6:0][7:0]	dline;		// delay line, dline[6] is oldest
	logic [6:0]		dval;
	logic [31:0]		crc;
	logic			body_now;	// next byte comes from the delay line
	logic			pad_now;	// next byte is a zero pad
	logic [1:0]		fcs_idx;
	logic [7:0]		next_byte;

	assign tx_ready = (state == TX_IDLE);

	always_comb begin
		body_now  = (state == TX_BODY) && dval[6];
		pad_now   = ((state == TX_BODY) || (state == TX_PAD)) && !body_now && (cnt < PAD_LEN);
		fcs_idx   = (state == TX_FCS) ? cnt[1:0] : 2'd0;
		if (body_now)
			next_byte = dline[6];
		else if (pad_now)
			next_byte = 8'h00;
		else
			next_byte = ~crc[8*fcs_idx +: 8];	// fcs, low byte first
	end

	// covers body and pad, sampled as they are put on the wire
	eth_crc32 u_crc (
		.clk_125mhz	(clk_125mhz),
		.rst		(rst),
		.init		(tx_ready && tx_bus.start),
		.update		(body_now || pad_now),
		.data		(next_byte),
		.crc		(crc)
	);

	// seven stages here plus the output register make eight
	always_ff @(posedge clk_125mhz)
		dline <= {dline[5:0], tx_bus.data};

	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			state      <= TX_IDLE;
			cnt        <= '0;
			accepting  <= 1'b0;
			dval       <= '0;
			gmii_tx.en <= 1'b0;
			gmii_tx.er <= 1'b0;
			tx_done    <= 1'b0;
		end else begin
			dval       <= {dval[5:0], accepting && tx_bus.data_valid};
			gmii_tx.er <= 1'b0;		// no error injection on transmit
			tx_done    <= 1'b0;
			if (tx_ready && tx_bus.start)
				accepting <= 1'b1;
			else if (!tx_bus.data_valid)
				accepting <= 1'b0;

			case (state)
				TX_IDLE: begin
					gmii_tx.en <= 1'b0;
					if (tx_bus.start) begin
						state        <= TX_PREAMBLE;
						cnt          <= '0;
						gmii_tx.en   <= 1'b1;
						gmii_tx.data <= PREAMBLE_BYTE;	// first of seven
					end
				end
				TX_PREAMBLE: begin
					gmii_tx.data <= (cnt == PRE_LAST) ? SFD_BYTE : PREAMBLE_BYTE;
					if (cnt == PRE_LAST) begin
						state <= TX_BODY;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 7'd1;
					end
				end
				TX_BODY, TX_PAD: begin
					gmii_tx.data <= next_byte;
					if (body_now || pad_now) begin
						if (cnt < PAD_LEN)
							cnt <= cnt + 7'd1;	// length only matters up to 60
						if (pad_now)
							state <= TX_PAD;
					end else begin
						state <= TX_FCS;		// fcs byte 0 goes out now
						cnt   <= 7'd1;
					end
				end
				TX_FCS: begin
					gmii_tx.data <= next_byte;
					if (cnt == FCS_LAST) begin
						state   <= TX_GAP;
						cnt     <= '0;
						tx_done <= 1'b1;		// lines up with the last fcs byte
					end else begin
						cnt <= cnt + 7'd1;
					end
				end
				TX_GAP: begin
					gmii_tx.en <= 1'b0;
					if (cnt == GAP_LAST)
						state <= TX_IDLE;
					else
						cnt <= cnt + 7'd1;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk_125mhz) disable iff (rst)
		tx_bus.start |-> tx_ready)
		else $error("tx framer: start while not ready");

	// gap is held for the full ifg after every frame
	assert property (@(posedge clk_125mhz) disable iff (rst)
		$fell(gmii_tx.en) |-> !tx_ready [*IFG_CYCLES])
		else $error("tx framer: inter-frame gap cut short");

endmodule

/* design/mac_perf_counters.sv */
`timescale 1ns/1ps

module mac_perf_counters import eth_pkg::*; #(
	parameter int COUNTER_WIDTH = 32
) (
	input  logic				clk_125mhz,
	input  logic				rst,
	input  logic				rx_good,
	input  logic				rx_crc_err,
	input  logic				rx_runt,
	input  logic				tx_done,
	input  logic				stat_req,
	input  perf_sel_t			stat_sel,
	output logic				stat_ack,
	output logic [COUNTER_WIDTH-1:0]	stat_value
);

	if (COUNTER_WIDTH < 8) begin : g_width_check
		$error("mac_perf_counters: COUNTER_WIDTH below 8");
	end

	logic [3:0]				events;
	logic [3:0][COUNTER_WIDTH-1:0]		count;

	// bit order follows perf_sel_t
	always_comb begin
		events             = '0;
		events[RX_GOOD]    = rx_good;
		events[RX_CRC_ERR] = rx_crc_err;
		events[RX_RUNT]    = rx_runt;
		events[TX_FRAMES]  = tx_done;
	end

	// counters stick at all ones instead of wrapping
	always_ff @(posedge clk_125mhz) begin
		if (rst) begin
			count <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (events[i] && (count[i] != '1))
					count[i] <= count[i] + COUNTER_WIDTH'(1);
			end
		end
	end

	// four-phase: ack follows req up and down, one cycle late
	always_ff @(posedge clk_125mhz) begin
		if (rst)
			stat_ack <= 1'b0;
		else if (stat_req && !stat_ack)
			stat_ack <= 1'b1;
		else if (!stat_req)
			stat_ack <= 1'b0;
	end

	// snapshot taken once per request, frozen while ack is up
	always_ff @(posedge clk_125mhz) begin
		if (stat_req && !stat_ack)
			stat_value <= count[stat_sel];
	end

	assert property (@(posedge clk_125mhz) disable iff (rst)
		$rose(stat_ack) |-> $past(stat_req))
		else $error("perf counters: ack without request");

endmodule

/* design/eth_mac_top.sv */
`timescale 1ns/1ps

module eth_mac_top import eth_pkg::*; #(
	parameter int COUNTER_WIDTH = 32
) (
	input  logic				clk_125mhz,
	input  logic				rst,

	input  gmii_bus_t			gmii_rx,	// from phy
	output gmii_bus_t			gmii_tx,	// to phy

	output eth_rx_bus_t			mac_rx_bus,
	input  eth_tx_bus_t			mac_tx_bus,
	output logic				mac_tx_ready,

	input  logic				stat_req,
	input  perf_sel_t			stat_sel,
	output logic				stat_ack,
	output logic [COUNTER_WIDTH-1:0]	stat_value
);

	logic	rx_good;
	logic	rx_crc_err;
	logic	rx_runt;
	logic	tx_done;

	gmii_rx_framer u_rx_framer (
		.clk_125mhz	(clk_125mhz),
		.rst		(rst),
		.gmii_rx	(gmii_rx),
		.rx_bus		(mac_rx_bus),
		.rx_good	(rx_good),
		.rx_crc_err	(rx_crc_err),
		.rx_runt	(rx_runt)
	);

	gmii_tx_framer u_tx_framer (
		.clk_125mhz	(clk_125mhz),
		.rst		(rst),
		.tx_bus		(mac_tx_bus),
		.tx_ready	(mac_tx_ready),
		.gmii_tx	(gmii_tx),
		.tx_done	(tx_done)
	);

	// both paths feed one counter block
	mac_perf_counters #(
		.COUNTER_WIDTH	(COUNTER_WIDTH)
	) u_perf_counters (
		.clk_125mhz	(clk_125mhz),
		.rst		(rst),
		.rx_good	(rx_good),
		.rx_crc_err	(rx_crc_err),
		.rx_runt	(rx_runt),
		.tx_done	(tx_done),
		.stat_req	(stat_req),
		.stat_sel	(stat_sel),
		.stat_ack	(stat_ack),
		.stat_value	(stat_value)
	);

endmodule

/* tests/eth_mac_tb.sv */
`timescale 1ns/1ps

module eth_mac_tb import eth_pkg::*; ();

	localparam int TIMEOUT = 400;		// cycles any single wait may take
	typedef logic [7:0] byte_q_t[$];

	logic			clk_125mhz;
	logic			rst;
	gmii_bus_t		gmii_rx;
	gmii_bus_t		gmii_tx;
	gmii_bus_t		rx_drive;	// phy side when not looped back
	logic			loopback;	// feed gmii_tx straight into gmii_rx
	eth_rx_bus_t		mac_rx_bus;
	eth_tx_bus_t		mac_tx_bus;
	logic			mac_tx_ready;
	logic			stat_req;
	perf_sel_t		stat_sel;
	logic			stat_ack;
	logic [15:0]		stat_value;

	logic [15:0]		lfsr;
	int			errors;
	int			err_at_start;
	int			tests_run;
	int			tests_failed;
	string			test_name;
	int			exp_count [4];	// expected totals, indexed by selector
	byte_q_t		payload;
	byte_q_t		tx_cap;		// bytes seen while gmii_tx.en is high
	byte_q_t		rx_cap;		// body bytes handed up on mac_rx_bus
	int			starts;
	int			commits;
	int			drops;
	int			tx_er_cycles;	// cycles with gmii_tx.er high
	int			en_rise;	// send loop cycle where en first shows, start is cycle 0

	eth_mac_top #(.COUNTER_WIDTH(16)) u_eth_mac_top (.*);

	always #10 clk_125mhz = ~clk_125mhz;

	assign gmii_rx = loopback ? gmii_tx : rx_drive;

	// 16-bit galois lfsr, one step per bit
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr[0];
			lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
		end
		return b;
	endfunction

	// msb-first crc on bit-reversed bytes, reflected and inverted at the end
	function automatic logic [31:0] ref_fcs(input byte_q_t q);
		logic [31:0] c;
		logic fb;
		c = '1;
		foreach (q[k])
			for (int i = 0; i < 8; i++) begin
				fb = c[31] ^ q[k][i];
				c = {c[30:0], 1'b0} ^ (fb ? 32'h04c11db7 : 32'h0);
			end
		return ~{<<{c}};
	endfunction

	// preamble, sfd, body, fcs low byte first
	function automatic byte_q_t wire_frame(input byte_q_t body);
		byte_q_t w;
		logic [31:0] fcs;
		fcs = ref_fcs(body);
		repeat (7) w.push_back(PREAMBLE_BYTE);
		w.push_back(SFD_BYTE);
		foreach (body[i]) w.push_back(body[i]);
		for (int i = 0; i < 4; i++) w.push_back(fcs[8*i +: 8]);
		return w;
	endfunction

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("** Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s: %s", test_name, msg);
		errors++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_at_start = errors;
		tx_cap.delete();
		rx_cap.delete();
		starts = 0;
		commits = 0;
		drops = 0;
		tx_er_cycles = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == err_at_start) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed", test_name);
		end
	endtask

	task automatic make_payload(input int n);
		payload.delete();
		repeat (n) payload.push_back(rand_byte());
	endtask

	// rx outputs are combinational on gmii_rx, so look well after the drive edge
	task automatic sample_outputs();
		#5;
		if (gmii_tx.en) tx_cap.push_back(gmii_tx.data);
		if (gmii_tx.er) tx_er_cycles++;
		if (mac_rx_bus.data_valid) rx_cap.push_back(mac_rx_bus.data);
		if (mac_rx_bus.start) starts++;
		if (mac_rx_bus.commit) commits++;
		if (mac_rx_bus.drop) drops++;
	endtask

	// start, then payload on back-to-back cycles; returns once the gap is over
	task automatic send_frame(output int gap);
		int n;
		int cyc;
		logic saw_en;
		logic done;
		n = 0;
		while (!mac_tx_ready && n < TIMEOUT) begin
			@(negedge clk_125mhz);
			n++;
		end
		if (!mac_tx_ready) report_failure("mac_tx_ready never rose before start");
		gap = 0;
		saw_en = 1'b0;
		done = 1'b0;
		cyc = 0;
		en_rise = -1;
		while (!done && cyc < TIMEOUT) begin
			@(negedge clk_125mhz);
			mac_tx_bus.start = (cyc == 0);
			mac_tx_bus.data_valid = (cyc >= 1) && (cyc <= payload.size());
			mac_tx_bus.data = mac_tx_bus.data_valid ? payload[cyc-1] : 8'h00;
			sample_outputs();
			if (gmii_tx.en) begin
				if (!saw_en)
					en_rise = cyc;
				saw_en = 1'b1;
			end else if (saw_en && mac_tx_ready)
				done = 1'b1;
			else if (saw_en)
				gap++;		// en low, not ready yet
			cyc++;
		end
		if (!done) report_failure("transmit frame did not finish in time");
	endtask

	task automatic drive_rx_frame(input byte_q_t w);
		int n;
		foreach (w[i]) begin
			@(negedge clk_125mhz);
			rx_drive = '{en: 1'b1, er: 1'b0, data: w[i]};
			sample_outputs();
		end
		n = 0;
		do begin
			@(negedge clk_125mhz);
			rx_drive = '0;
			sample_outputs();
			n++;
		end while (commits + drops == 0 && n < TIMEOUT);
		if (commits + drops == 0) report_failure("no commit or drop after the frame ended");
	endtask

	// four-phase read, also checks the ack timing on both edges
	task automatic read_counter(input perf_sel_t sel, output logic [15:0] value);
		int n;
		@(negedge clk_125mhz);
		stat_sel = sel;
		stat_req = 1'b1;
		n = 0;
		do begin
			@(negedge clk_125mhz);
			n++;
		end while (!stat_ack && n < TIMEOUT);
		if (!stat_ack) report_failure("stat_ack never rose");
		else compare("ack latency", 32'd1, 32'(n));
		value = stat_value;
		stat_req = 1'b0;
		n = 0;
		do begin
			@(negedge clk_125mhz);
			n++;
		end while (stat_ack && n < TIMEOUT);
		if (stat_ack) report_failure("stat_ack stayed high after stat_req dropped");
		else compare("ack release", 32'd1, 32'(n));
	endtask

	task automatic check_counter(input perf_sel_t sel);
		logic [15:0] v;
		read_counter(sel, v);
		compare(sel.name(), 32'(exp_count[sel]), 32'(v));
	endtask

	task automatic test_reset();
		begin_test("reset");
		compare("mac_tx_ready", 32'd1, 32'(mac_tx_ready));
		compare("gmii_tx.en", 32'd0, 32'(gmii_tx.en));
		compare("gmii_tx.er", 32'd0, 32'(gmii_tx.er));
		compare("rx pulses", 32'd0, 32'({mac_rx_bus.start, mac_rx_bus.data_valid,
			mac_rx_bus.commit, mac_rx_bus.drop}));
		for (int s = 0; s < 4; s++)
			check_counter(perf_sel_t'(s));
		end_test();
	endtask

	task automatic test_tx_framing();
		byte_q_t body;
		byte_q_t exp;
		int gap;
		begin_test("tx_framing");
		make_payload(20);
		send_frame(gap);
		exp_count[TX_FRAMES]++;
		body = payload;
		while (body.size() < MIN_BODY_BYTES) body.push_back(8'h00);	// zero pad
		exp = wire_frame(body);
		compare("en rise after start", 32'd1, 32'(en_rise));
		compare("en cycles", 32'd72, 32'(tx_cap.size()));
		foreach (exp[i])
			if (i < tx_cap.size())
				compare($sformatf("byte %0d", i), 32'(exp[i]), 32'(tx_cap[i]));
		compare("er cycles", 32'd0, 32'(tx_er_cycles));
		compare("gap cycles", 32'(IFG_CYCLES), 32'(gap));
		end_test();
	endtask

	task automatic test_loopback();
		int gap;
		begin_test("loopback_rx");
		loopback = 1'b1;
		make_payload(100);
		send_frame(gap);
		loopback = 1'b0;
		exp_count[TX_FRAMES]++;
		exp_count[RX_GOOD]++;
		compare("rx length", 32'd100, 32'(rx_cap.size()));
		foreach (payload[i])
			if (i < rx_cap.size())
				compare($sformatf("rx byte %0d", i), 32'(payload[i]), 32'(rx_cap[i]));
		compare("start pulses", 32'd1, 32'(starts));
		compare("commit", 32'd1, 32'(commits));
		compare("drop", 32'd0, 32'(drops));
		end_test();
	endtask

	task automatic test_bad_crc();
		byte_q_t w;
		begin_test("bad_crc");
		make_payload(60);
		w = wire_frame(payload);
		w[w.size()-1] = w[w.size()-1] ^ 8'hff;		// corrupt last fcs byte
		drive_rx_frame(w);
		exp_count[RX_CRC_ERR]++;
		compare("drop", 32'd1, 32'(drops));
		compare("commit", 32'd0, 32'(commits));
		check_counter(RX_CRC_ERR);
		end_test();
	endtask

	task automatic test_runt();
		begin_test("runt");
		make_payload(30);
		drive_rx_frame(wire_frame(payload));
		exp_count[RX_RUNT]++;
		compare("drop", 32'd1, 32'(drops));
		compare("commit", 32'd0, 32'(commits));
		check_counter(RX_RUNT);
		end_test();
	endtask

	task automatic test_totals();
		begin_test("counter_totals");
		for (int s = 0; s < 4; s++)
			check_counter(perf_sel_t'(s));
		end_test();
	endtask

	initial begin
		clk_125mhz = 1'b0;
		rst = 1'b1;
		loopback = 1'b0;
		rx_drive = '0;
		mac_tx_bus = '0;
		stat_req = 1'b0;
		stat_sel = RX_GOOD;
		lfsr = 16'd58630;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		foreach (exp_count[i]) exp_count[i] = 0;
		repeat (2) @(negedge clk_125mhz);
		rst = 1'b0;
		test_reset();
		test_tx_framing();
		test_loopback();
		test_bad_crc();
		test_runt();
		test_totals();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* tb.f */
design/eth_pkg.sv
design/eth_crc32.sv
design/gmii_rx_framer.sv
design/gmii_tx_framer.sv
design/mac_perf_counters.sv
design/eth_mac_top.sv
tests/eth_mac_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module eth_mac_tb -f tb.f -o eth_mac_sim
./obj_dir/eth_mac_sim | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
